/* verilog.f */
bus_pkg.sv
flow_pkg.sv
byte_packer.sv
credit_word_fifo.sv
mem_write_port.sv
bus_sizer_top.sv
sizer_checker.sv
tb_bus_sizer.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_bus_sizer
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf $(OBJ_DIR)

/* tb_bus_sizer.sv */
`timescale 1ns/100ps

module tb_bus_sizer;

    import bus_pkg::*;

    localparam int FIFO_DEPTH = 4;
    localparam int WDT_LIMIT  = 16;
    localparam int TIMEOUT    = 2000;

    logic          wb_clk;
    logic          rst_n;
    logic          byte_stb;
    addr_t         byte_adr;
    byte_t         byte_dat;
    logic          byte_ack;
    logic          flush;
    logic          mem_stb;
    word_adr_t     mem_adr;
    word_t         mem_dat;
    sel_t          mem_sel;
    logic          mem_ack;
    logic          wdt_exc;

    integer        seed;
    int            ack_delay;
    int            ack_cnt;
    logic          drop_en;
    word_adr_t     drop_adr;
    bit            timed_out;
    int            withheld;

    always #2 wb_clk = ~wb_clk;

    bus_sizer_top #(
        .FIFO_DEPTH ( FIFO_DEPTH ),
        .WDT_LIMIT  ( WDT_LIMIT  )
    ) dut_i (
        .byte_stb_i ( byte_stb ),
        .byte_adr_i ( byte_adr ),
        .byte_dat_i ( byte_dat ),
        .byte_ack_o ( byte_ack ),
        .flush_i    ( flush    ),
        .mem_stb_o  ( mem_stb  ),
        .mem_adr_o  ( mem_adr  ),
        .mem_dat_o  ( mem_dat  ),
        .mem_sel_o  ( mem_sel  ),
        .mem_ack_i  ( mem_ack  ),
        .wdt_exc_o  ( wdt_exc  ),
        .wb_clk_i   ( wb_clk   ),
        .rst_n_i    ( rst_n    )
    );

    sizer_checker chk_i (
        .wb_clk_i   ( wb_clk   ),
        .rst_n_i    ( rst_n    ),
        .byte_stb_i ( byte_stb ),
        .byte_adr_i ( byte_adr ),
        .byte_dat_i ( byte_dat ),
        .byte_ack_i ( byte_ack ),
        .flush_i    ( flush    ),
        .mem_stb_i  ( mem_stb  ),
        .mem_adr_i  ( mem_adr  ),
        .mem_dat_i  ( mem_dat  ),
        .mem_sel_i  ( mem_sel  ),
        .mem_ack_i  ( mem_ack  ),
        .wdt_exc_i  ( wdt_exc  )
    );

    // --------------------------------------------------
    // Slave model
    // --------------------------------------------------
    // Acks after ack_delay wait cycles and never acks the drop word
    always @(negedge wb_clk) begin
        if (!rst_n) begin
            mem_ack <= 1'b0;
            ack_cnt <= 0;
        end else if (mem_ack) begin
            mem_ack <= 1'b0;
            ack_cnt <= 0;
        end else if (mem_stb && !(drop_en && (mem_adr == drop_adr))) begin
            if (ack_cnt >= ack_delay) begin
                mem_ack <= 1'b1;
            end else begin
                ack_cnt <= ack_cnt + 1;
            end
        end else begin
            ack_cnt <= 0;
        end
    end

    // Called and returns on a falling edge
    task automatic send_byte(input addr_t adr, input byte_t dat, output int waits);
        int n;
        n = 0;
        waits = 0;
        if (timed_out) begin
            return;
        end
        byte_stb = 1'b1;
        byte_adr = adr;
        byte_dat = dat;
        @(posedge wb_clk);
        while (!byte_ack && (n < TIMEOUT)) begin
            n++;
            @(posedge wb_clk);
        end
        @(negedge wb_clk);
        byte_stb = 1'b0;
        waits    = n;
        withheld += n;
        if (n >= TIMEOUT) begin
            $display("Timeout: byte to address %h was never accepted", adr);
            timed_out = 1'b1;
        end
    endtask

    // Wait until every expected word has left the bus
    task automatic drain(input bit use_flush);
        int n;
        n = 0;
        if (timed_out) begin
            return;
        end
        flush = use_flush;
        repeat (2) @(negedge wb_clk);
        while (((chk_i.pending() != 0) || mem_stb) && (n < TIMEOUT)) begin
            n++;
            @(negedge wb_clk);
        end
        flush = 1'b0;
        @(negedge wb_clk);
        if (n >= TIMEOUT) begin
            $display("Timeout: expected words never reached the slave bus");
            timed_out = 1'b1;
        end
    endtask

    task automatic finish_run();
        chk_i.report_counts();
        if (!timed_out && (chk_i.error_total() == 0)) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    initial begin
        int w;
        int r;
        seed      = 65;
        wb_clk    = 1'b0;
        rst_n     = 1'b0;
        byte_stb  = 1'b0;
        byte_adr  = '0;
        byte_dat  = '0;
        flush     = 1'b0;
        mem_ack   = 1'b0;
        ack_delay = 1;
        drop_en   = 1'b0;
        drop_adr  = '0;
        timed_out = 1'b0;
        withheld  = 0;
        repeat (4) @(posedge wb_clk);
        @(negedge wb_clk);
        rst_n = 1'b1;

        chk_i.start_test("reset");
        if ((mem_stb !== 1'b0) || (wdt_exc !== 1'b0)) begin
            chk_i.note_error("mem_stb_o or wdt_exc_o is not low after reset");
        end
        send_byte(16'h0010, 8'hA5, w);
        if (w != 0) begin
            chk_i.note_error("first byte was not accepted in its strobe cycle");
        end
        drain(1'b1);
        chk_i.end_test(0);

        chk_i.start_test("full_word");
        send_byte(16'h0040, 8'h11, w);
        send_byte(16'h0041, 8'h22, w);
        send_byte(16'h0042, 8'h33, w);
        send_byte(16'h0043, 8'h44, w);
        drain(1'b0);
        chk_i.end_test(0);

        chk_i.start_test("random_scatter");
        for (int i = 0; i < 20; i++) begin
            r = $random(seed);
            send_byte(16'h0200 + addr_t'(r[3:0]), byte_t'($random(seed)), w);
        end
        // Last byte leaves a partial word for the flush
        send_byte(16'h0201, 8'h5A, w);
        drain(1'b1);
        chk_i.end_test(0);

        chk_i.start_test("repeat_lane");
        send_byte(16'h0300, 8'hAA, w);
        send_byte(16'h0301, 8'hBB, w);
        send_byte(16'h0300, 8'hCC, w);
        send_byte(16'h0301, 8'hDD, w);
        send_byte(16'h0300, 8'hEE, w);
        drain(1'b1);
        chk_i.end_test(0);

        // Slow slave fills the buffer
        chk_i.start_test("back_pressure");
        ack_delay = 10;
        withheld  = 0;
        for (int i = 0; i < 12; i++) begin
            send_byte(16'h0403 + addr_t'(i * 4), byte_t'(8'h50 + i), w);
        end
        drain(1'b0);
        if (withheld == 0) begin
            chk_i.note_error("byte_ack_o was never withheld under back-pressure");
        end
        chk_i.end_test(0);

        chk_i.start_test("watchdog");
        ack_delay = 2;
        drop_en   = 1'b1;
        drop_adr  = word_adr_t'(16'h0520 >> 2);
        for (int i = 0; i < 12; i++) begin
            send_byte(16'h0500 + addr_t'((i / 4) * 32 + (i % 4)), byte_t'(8'h80 + i), w);
        end
        drain(1'b0);
        drop_en = 1'b0;
        chk_i.end_test(1);

        finish_run();
    end

endmodule

/* sizer_checker.sv */
`timescale 1ns/100ps

module sizer_checker (
    input  logic                wb_clk_i,
    input  logic                rst_n_i,
    input  logic                byte_stb_i,
    input  bus_pkg::addr_t      byte_adr_i,
    input  bus_pkg::byte_t      byte_dat_i,
    input  logic                byte_ack_i,
    input  logic                flush_i,
    input  logic                mem_stb_i,
    input  bus_pkg::word_adr_t  mem_adr_i,
    input  bus_pkg::word_t      mem_dat_i,
    input  bus_pkg::sel_t       mem_sel_i,
    input  logic                mem_ack_i,
    input  logic                wdt_exc_i
);

    import bus_pkg::*;

    // Expected entry is {word address, selects, data}
    logic [49:0]   exp_q [$];
    logic [49:0]   head;

    // Reference copy of the open word
    logic          ref_open = 1'b0;
    word_adr_t     ref_adr  = '0;
    sel_t          ref_sel  = '0;
    word_t         ref_dat  = '0;

    string         test_name    = "none";
    int            test_errors  = 0;
    int            test_drops   = 0;
    int            total_errors = 0;
    int            tests_run    = 0;
    int            tests_failed = 0;

    // --------------------------------------------------
    // Reference packing model
    // --------------------------------------------------
    function automatic void pack_event(input bit is_flush, input addr_t adr, input byte_t dat);
        word_adr_t wadr;
        int        lane;
        wadr = adr[15:2];
        lane = int'(adr[1:0]);
        if (is_flush) begin
            if (ref_open) begin
                exp_q.push_back({ref_adr, ref_sel, ref_dat});
                ref_open = 1'b0;
            end
            return;
        end
        // Other word or a lane already taken closes the open word
        if (ref_open && ((wadr != ref_adr) || ref_sel[lane])) begin
            exp_q.push_back({ref_adr, ref_sel, ref_dat});
            ref_open = 1'b0;
        end
        if (!ref_open) begin
            ref_open = 1'b1;
            ref_adr  = wadr;
            ref_sel  = '0;
            ref_dat  = '0;
        end
        ref_sel[lane]        = 1'b1;
        ref_dat[lane*8 +: 8] = dat;
        if (lane == 3) begin
            exp_q.push_back({ref_adr, ref_sel, ref_dat});
            ref_open = 1'b0;
        end
    endfunction

    function automatic int pending();
        return exp_q.size() + (ref_open ? 1 : 0);
    endfunction

    function automatic int error_total();
        return total_errors;
    endfunction

    task automatic note_error(input string msg);
        $display("Error in %s: %s", test_name, msg);
        test_errors++;
        total_errors++;
    endtask

    task automatic report_mismatch(input logic [49:0] exp_w, input logic [49:0] act_w);
        $display("Mismatch %s: expected adr=%h sel=%h dat=%h, actual adr=%h sel=%h dat=%h",
                 test_name, exp_w[49:36], exp_w[35:32], exp_w[31:0],
                 act_w[49:36], act_w[35:32], act_w[31:0]);
        test_errors++;
        total_errors++;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        test_drops  = 0;
    endtask

    task automatic end_test(input int exp_drops);
        if (test_drops != exp_drops) begin
            note_error($sformatf("watchdog fired %0d times instead of %0d",
                                 test_drops, exp_drops));
        end
        if (pending() != 0) begin
            note_error("expected words never appeared on the slave bus");
        end
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("Test %s: %s (%0d errors)", test_name,
                 (test_errors == 0) ? "passed" : "failed", test_errors);
    endtask

    task automatic report_counts();
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, total_errors);
    endtask

    // --------------------------------------------------
    // Monitor
    // --------------------------------------------------
    always @(posedge wb_clk_i) begin
        if (rst_n_i) begin
            if (byte_stb_i && byte_ack_i) begin
                pack_event(1'b0, byte_adr_i, byte_dat_i);
            end
            if (flush_i) begin
                pack_event(1'b1, '0, '0);
            end
            // Dropped word leaves the expected list
            if (wdt_exc_i) begin
                test_drops++;
                if (exp_q.size() == 0) begin
                    note_error("watchdog fired with no word outstanding");
                end else begin
                    void'(exp_q.pop_front());
                end
            end
            if (mem_stb_i && mem_ack_i) begin
                if (exp_q.size() == 0) begin
                    note_error($sformatf("unexpected write to word %h", mem_adr_i));
                end else begin
                    head = exp_q.pop_front();
                    if (head !== {mem_adr_i, mem_sel_i, mem_dat_i}) begin
                        report_mismatch(head, {mem_adr_i, mem_sel_i, mem_dat_i});
                    end
                end
            end
        end
    end

endmodule

/* bus_sizer_top.sv */
`timescale 1ns/100ps

module bus_sizer_top #(
    parameter int FIFO_DEPTH = 4,
    parameter int WDT_LIMIT  = 16
) (
    // 8-bit byte side
    input  logic                   byte_stb_i,
    input  bus_pkg::addr_t         byte_adr_i,
    input  bus_pkg::byte_t         byte_dat_i,
    output logic                   byte_ack_o,
    input  logic                   flush_i,

    // 32-bit slave side
    output logic                   mem_stb_o,
    output bus_pkg::word_adr_t     mem_adr_o,
    output bus_pkg::word_t         mem_dat_o,
    output bus_pkg::sel_t          mem_sel_o,
    input  logic                   mem_ack_i,
    output logic                   wdt_exc_o,

    input  logic                   wb_clk_i,
    input  logic                   rst_n_i
);

    import bus_pkg::*;

    // --------------------------------------------------
    // Packer to buffer
    // --------------------------------------------------
    logic          push;
    word_adr_t     push_adr;
    word_lanes_u   push_dat;
    sel_t          push_sel;
    logic          credit;

    // --------------------------------------------------
    // Buffer to port
    // --------------------------------------------------
    logic          head_valid;
    word_adr_t     head_adr;
    word_lanes_u   head_dat;
    sel_t          head_sel;
    logic          pop;

    byte_packer #(
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) u_packer (
        .wb_clk_i   ( wb_clk_i   ),
        .rst_n_i    ( rst_n_i    ),
        .byte_stb_i ( byte_stb_i ),
        .byte_adr_i ( byte_adr_i ),
        .byte_dat_i ( byte_dat_i ),
        .flush_i    ( flush_i    ),
        .credit_i   ( credit     ),
        .byte_ack_o ( byte_ack_o ),
        .push_o     ( push       ),
        .push_adr_o ( push_adr   ),
        .push_dat_o ( push_dat   ),
        .push_sel_o ( push_sel   )
    );

    credit_word_fifo #(
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) u_fifo (
        .wb_clk_i     ( wb_clk_i   ),
        .rst_n_i      ( rst_n_i    ),
        .push_i       ( push       ),
        .push_adr_i   ( push_adr   ),
        .push_dat_i   ( push_dat   ),
        .push_sel_i   ( push_sel   ),
        .pop_i        ( pop        ),
        .credit_o     ( credit     ),
        .head_valid_o ( head_valid ),
        .head_adr_o   ( head_adr   ),
        .head_dat_o   ( head_dat   ),
        .head_sel_o   ( head_sel   )
    );

    mem_write_port #(
        .WDT_LIMIT ( WDT_LIMIT )
    ) u_port (
        .wb_clk_i     ( wb_clk_i   ),
        .rst_n_i      ( rst_n_i    ),
        .head_valid_i ( head_valid ),
        .head_adr_i   ( head_adr   ),
        .head_dat_i   ( head_dat   ),
        .head_sel_i   ( head_sel   ),
        .mem_ack_i    ( mem_ack_i  ),
        .pop_o        ( pop        ),
        .mem_stb_o    ( mem_stb_o  ),
        .mem_adr_o    ( mem_adr_o  ),
        .mem_dat_o    ( mem_dat_o  ),
        .mem_sel_o    ( mem_sel_o  ),
        .wdt_exc_o    ( wdt_exc_o  )
    );

endmodule

/* mem_write_port.sv */
`timescale 1ns/100ps

module mem_write_port #(
    parameter int WDT_LIMIT = 16
) (
    input  logic                   wb_clk_i,
    input  logic                   rst_n_i,
    input  logic                   head_valid_i,
    input  bus_pkg::word_adr_t     head_adr_i,
    input  bus_pkg::word_lanes_u   head_dat_i,
    input  bus_pkg::sel_t          head_sel_i,
    input  logic                   mem_ack_i,
    output logic                   pop_o,
    output logic                   mem_stb_o,
    output bus_pkg::word_adr_t     mem_adr_o,
    output bus_pkg::word_t         mem_dat_o,
    output bus_pkg::sel_t          mem_sel_o,
    output logic                   wdt_exc_o
);

    localparam int WDT_W = $clog2(WDT_LIMIT + 1);

    logic [WDT_W-1:0]  wdt_cnt_q;
    logic              wdt_hit;
    logic              bus_free;

    // Slave gave up on this word
    assign wdt_hit  = mem_stb_o && !mem_ack_i && (wdt_cnt_q == WDT_W'(WDT_LIMIT - 1));

    // Bus is free now or after this edge
    assign bus_free = !mem_stb_o || mem_ack_i || wdt_hit;
    assign pop_o    = head_valid_i && bus_free;

    // --------------------------------------------------
    // Strobe and watchdog
    // --------------------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            mem_stb_o <= 1'b0;
            wdt_exc_o <= 1'b0;
            wdt_cnt_q <= '0;
        end else begin
            wdt_exc_o <= wdt_hit;
            if (bus_free) begin
                mem_stb_o <= pop_o;
                wdt_cnt_q <= '0;
            end else begin
                wdt_cnt_q <= wdt_cnt_q + 1'b1;
            end
        end
    end

    // Payload loads only with a popped word
    always_ff @(posedge wb_clk_i) begin
        if (pop_o) begin
            mem_adr_o <= head_adr_i;
            mem_dat_o <= head_dat_i.word;
            mem_sel_o <= head_sel_i;
        end
    end

    // Word stays on the bus until acknowledged or dropped
    a_bus_stable : assert property (
        @(posedge wb_clk_i) disable iff (!rst_n_i)
        (mem_stb_o && !mem_ack_i && !wdt_hit) |=>
            (mem_stb_o && $stable(mem_adr_o) && $stable(mem_dat_o) && $stable(mem_sel_o))
    );

endmodule

/* credit_word_fifo.sv */
`timescale 1ns/100ps

module credit_word_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                   wb_clk_i,
    input  logic                   rst_n_i,
    input  logic                   push_i,
    input  bus_pkg::word_adr_t     push_adr_i,
    input  bus_pkg::word_lanes_u   push_dat_i,
    input  bus_pkg::sel_t          push_sel_i,
    input  logic                   pop_i,
    output logic                   credit_o,
    output logic                   head_valid_o,
    output bus_pkg::word_adr_t     head_adr_o,
    output bus_pkg::word_lanes_u   head_dat_o,
    output bus_pkg::sel_t          head_sel_o
);

    import bus_pkg::*;
    import flow_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    // Entry storage
    word_adr_t     adr_mem [FIFO_DEPTH];
    word_lanes_u   dat_mem [FIFO_DEPTH];
    sel_t          sel_mem [FIFO_DEPTH];

    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    credit_t           count_q;

    // Wrap at the configured depth, not at a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // --------------------------------------------------
    // Pointers, fill level and credit return
    // --------------------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            count_q  <= count_q + credit_t'(push_i) - credit_t'(pop_i);
            // One credit back per freed slot
            credit_o <= pop_i;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (push_i) begin
            adr_mem[wr_ptr_q] <= push_adr_i;
            dat_mem[wr_ptr_q] <= push_dat_i;
            sel_mem[wr_ptr_q] <= push_sel_i;
        end
    end

    // Head is read straight from the store
    assign head_valid_o = (count_q != '0);
    assign head_adr_o   = adr_mem[rd_ptr_q];
    assign head_dat_o   = dat_mem[rd_ptr_q];
    assign head_sel_o   = sel_mem[rd_ptr_q];

    // --------------------------------------------------
    // Credit loop checks
    // --------------------------------------------------
    // Packer credits must keep pushes away from a full store
    a_no_push_full : assert property (
        @(posedge wb_clk_i) disable iff (!rst_n_i)
        push_i |-> (count_q < credit_t'(FIFO_DEPTH)) || pop_i
    );

    // Port only takes a head that is there
    a_no_pop_empty : assert property (
        @(posedge wb_clk_i) disable iff (!rst_n_i)
        pop_i |-> head_valid_o
    );

endmodule

/* byte_packer.sv */
`timescale 1ns/100ps

module byte_packer #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                   wb_clk_i,
    input  logic                   rst_n_i,
    input  logic                   byte_stb_i,
    input  bus_pkg::addr_t         byte_adr_i,
    input  bus_pkg::byte_t         byte_dat_i,
    input  logic                   flush_i,
    input  logic                   credit_i,
    output logic                   byte_ack_o,
    output logic                   push_o,
    output bus_pkg::word_adr_t     push_adr_o,
    output bus_pkg::word_lanes_u   push_dat_o,
    output bus_pkg::sel_t          push_sel_o
);

    import bus_pkg::*;
    import flow_pkg::*;

    // Open word being gathered
    logic          open_q;
    logic          done_q;
    word_adr_t     open_adr_q;
    word_lanes_u   open_dat_q;
    sel_t          open_sel_q;
    credit_t       credit_cnt_q;

    // Next state of the open word
    logic          open_d;
    logic          done_d;
    word_adr_t     adr_d;
    word_lanes_u   dat_d;
    sel_t          sel_d;

    // Incoming byte decoded
    lane_t         lane;
    word_adr_t     wadr;
    sel_t          lane_sel;
    logic          lane_last;
    logic          credit_ok;
    logic          merge_ok;
    word_lanes_u   fresh;
    word_lanes_u   merged;

    // Word leaving towards the buffer
    logic          accept;
    logic          emit;
    word_adr_t     emit_adr;
    word_lanes_u   emit_dat;
    sel_t          emit_sel;

    assign lane      = byte_adr_i[1:0];
    assign wadr      = byte_adr_i[ADDR_W-1:2];
    assign lane_sel  = sel_t'(1) << lane;
    assign lane_last = (lane == lane_t'(LANES - 1));
    assign credit_ok = (credit_cnt_q != '0);

    // Byte may join the open word without forcing it out
    assign merge_ok  = open_q && !done_q && (wadr == open_adr_q) &&
                       !(|(open_sel_q & lane_sel));

    // --------------------------------------------------
    // Acceptance and packing decision
    // --------------------------------------------------
    always_comb begin
        fresh              = '0;
        fresh.lanes[lane]  = byte_dat_i;
        merged             = open_dat_q;
        merged.lanes[lane] = byte_dat_i;

        accept   = 1'b0;
        emit     = 1'b0;
        emit_adr = open_adr_q;
        emit_dat = open_dat_q;
        emit_sel = open_sel_q;
        open_d   = open_q;
        done_d   = done_q;
        adr_d    = open_adr_q;
        dat_d    = open_dat_q;
        sel_d    = open_sel_q;

        if (byte_stb_i) begin
            if (!open_q) begin
                accept = 1'b1;
                if (lane_last && credit_ok) begin
                    // Lone lane 3 byte goes straight out
                    emit     = 1'b1;
                    emit_adr = wadr;
                    emit_dat = fresh;
                    emit_sel = lane_sel;
                end else begin
                    open_d = 1'b1;
                    done_d = lane_last;
                    adr_d  = wadr;
                    dat_d  = fresh;
                    sel_d  = lane_sel;
                end
            end else if (merge_ok) begin
                accept = 1'b1;
                if (lane_last && credit_ok) begin
                    emit     = 1'b1;
                    emit_dat = merged;
                    emit_sel = open_sel_q | lane_sel;
                    open_d   = 1'b0;
                end else begin
                    // Without a credit a completed word waits here
                    done_d = lane_last;
                    dat_d  = merged;
                    sel_d  = open_sel_q | lane_sel;
                end
            end else if (credit_ok) begin
                // Other word or repeated lane pushes the old word out
                accept = 1'b1;
                emit   = 1'b1;
                open_d = 1'b1;
                done_d = lane_last;
                adr_d  = wadr;
                dat_d  = fresh;
                sel_d  = lane_sel;
            end
        end else if (open_q && (done_q || flush_i) && credit_ok) begin
            emit   = 1'b1;
            open_d = 1'b0;
            done_d = 1'b0;
        end
    end

    assign byte_ack_o = accept;

    // --------------------------------------------------
    // State and credit registers
    // --------------------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            open_q       <= 1'b0;
            done_q       <= 1'b0;
            push_o       <= 1'b0;
            credit_cnt_q <= credit_t'(FIFO_DEPTH);
        end else begin
            open_q       <= open_d;
            done_q       <= done_d;
            push_o       <= emit;
            credit_cnt_q <= credit_cnt_q - credit_t'(emit) + credit_t'(credit_i);
        end
    end

    always_ff @(posedge wb_clk_i) begin
        open_adr_q <= adr_d;
        open_dat_q <= dat_d;
        open_sel_q <= sel_d;
        if (emit) begin
            push_adr_o <= emit_adr;
            push_dat_o <= emit_dat;
            push_sel_o <= emit_sel;
        end
    end

    // A push at zero credits or a surplus returned credit
    // drives the count out of its range
    a_credit_in_range : assert property (
        @(posedge wb_clk_i) disable iff (!rst_n_i)
        credit_cnt_q <= credit_t'(FIFO_DEPTH)
    );

endmodule

/* flow_pkg.sv */
package flow_pkg;

    // --------------------------------------------------
    // Flow-control limits
    // --------------------------------------------------
    // Deepest word buffer the credit counter can cover
    localparam int MAX_FIFO_DEPTH = 16;

    // Credit and fill counters, 0 up to MAX_FIFO_DEPTH inclusive
    typedef logic [$clog2(MAX_FIFO_DEPTH + 1)-1:0] credit_t;

endpackage

/* bus_pkg.sv */
package bus_pkg;

    // --------------------------------------------------
    // Bus geometry
    // --------------------------------------------------
    // Byte address of the 8-bit side
    localparam int ADDR_W = 16;
    // Byte lanes in one slave word
    localparam int LANES  = 4;

    // --------------------------------------------------
    // Basic types
    // --------------------------------------------------
    typedef logic [7:0]          byte_t;
    typedef logic [ADDR_W-1:0]   addr_t;
    // Byte address with the two lane bits removed
    typedef logic [ADDR_W-3:0]   word_adr_t;
    typedef logic [1:0]          lane_t;
    typedef logic [LANES-1:0]    sel_t;
    typedef logic [31:0]         word_t;

    // --------------------------------------------------
    // Word with a per-lane view
    // --------------------------------------------------
    // Packer fills single lanes, port reads the whole word
    // Lane 0 is the least significant byte
    typedef union packed {
        word_t                word;
        byte_t [LANES-1:0]    lanes;
    } word_lanes_u;

endpackage
